/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cache_controller
RTL_TOP   ?= cache_controller
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter design/%,$(SRCS))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
design/cache_geom_pkg.sv
design/cache_ctrl_pkg.sv
design/line_buffer.sv
design/way_lookup.sv
design/miss_fsm.sv
design/cache_controller.sv
tb/cache_env_model.sv
tb/tb_cache_controller.sv

/* design/cache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_controller (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  input  logic [cache_geom_pkg::word_w-1:0]                            cpu_req_addr,
  input  logic [cache_geom_pkg::word_w-1:0]                            cpu_req_datain,
  input  logic                                                         cpu_req_rw,
  input  logic                                                         cpu_req_enable,
  output logic [cache_geom_pkg::word_w-1:0]                            cpu_res_dataout,
  output logic                                                         cpu_res_ready,
  output logic                                                         cache_enable,
  output logic                                                         cache_rw,
  output logic [cache_geom_pkg::index_w-1:0]                           cache_index,
  input  logic                                                         cache_ready,
  input  logic [cache_geom_pkg::ways-1:0]                              cand_valid,
  input  logic [cache_geom_pkg::ways-1:0]                              cand_dirty,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   cand_age,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   cand_tag,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] cand_data,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   way_age,
  output logic [cache_geom_pkg::tag_w-1:0]                             wr_tag,
  output logic                                                         wr_dirty,
  output logic [cache_geom_pkg::block_w-1:0]                           wr_data,
  output logic [cache_geom_pkg::ways-1:0]                              bank_selector,
  output logic [cache_geom_pkg::word_w-1:0]                            mem_req_addr,
  output logic [cache_geom_pkg::block_w-1:0]                           mem_req_dataout,
  output logic                                                         mem_req_rw,
  output logic                                                         mem_req_enable,
  input  logic [cache_geom_pkg::block_w-1:0]                           mem_req_datain,
  input  logic                                                         mem_req_ready
);

  logic                                                         req_load, cand_load, fill_load;
  logic [cache_geom_pkg::tag_w-1:0]                             req_tag;
  logic [cache_geom_pkg::index_w-1:0]                           req_index;
  logic [cache_geom_pkg::offset_w-1:0]                          req_offset;
  logic                                                         req_rw;
  logic [cache_geom_pkg::word_w-1:0]                            req_data;
  logic [cache_geom_pkg::ways-1:0]                              line_valid, line_dirty;
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   line_age;
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   line_tag;
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] line_data;
  logic [cache_geom_pkg::block_w-1:0]                           fill_block;
  logic                                                         hit, evict_needed;
  logic [cache_geom_pkg::tag_w-1:0]                             victim_tag;

  line_buffer line_buffer_inst (.*);  // Held request, candidates and fill block

  // Victim block goes out on the memory write, read word back to the CPU
  way_lookup way_lookup_inst (
    .victim_block (mem_req_dataout),
    .read_word    (cpu_res_dataout),
    .*
  );

  miss_fsm miss_fsm_inst (.*);

endmodule

`default_nettype wire

/* design/cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

  // Access sequencer states
  typedef enum logic [2:0] {
    idle     = 3'd0,  // Waiting for a CPU request
    lookup   = 3'd1,  // Array read of the four candidates
    evict    = 3'd2,  // Dirty victim written to memory
    allocate = 3'd3,  // Block fetched from memory
    update   = 3'd4,  // Array write of line and ages
    respond  = 3'd5   // One-cycle answer to the CPU
  } ctrl_state_e;

  // Age 0 is most recently used, age 3 is the replacement victim
  localparam logic [cache_geom_pkg::age_w-1:0] age_newest = 2'd0;
  localparam logic [cache_geom_pkg::age_w-1:0] age_oldest = 2'd3;

endpackage

`default_nettype wire

/* design/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

  localparam int word_w      = 32;                          // CPU word
  localparam int offset_w    = 4;                           // Word select inside a block
  localparam int index_w     = 7;                           // 128 sets
  localparam int tag_w       = word_w - offset_w - index_w; // 21 bits
  localparam int block_words = 16;
  localparam int block_w     = block_words * word_w;        // 512 bits per line
  localparam int ways        = 4;
  localparam int age_w       = 2;                           // Enough to rank four ways

  // Word address layout, tag in the top bits
  typedef struct packed {
    logic [tag_w-1:0]    tag;
    logic [index_w-1:0]  index;
    logic [offset_w-1:0] offset;
  } cache_addr_t;

  // Same word seen raw or split into fields
  typedef union packed {
    logic [word_w-1:0] raw;
    cache_addr_t       fields;
  } cache_addr_u;

  // Replace one word of a block, used for write hits and write fills
  function automatic logic [block_w-1:0] merge_word(input logic [block_w-1:0]  block,
                                                    input logic [offset_w-1:0] offset,
                                                    input logic [word_w-1:0]   word);
    logic [block_w-1:0] merged;
    merged = block;
    merged[offset*word_w +: word_w] = word;
    return merged;
  endfunction

endpackage

`default_nettype wire

/* design/line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  input  logic                                                         req_load,
  input  logic                                                         cand_load,
  input  logic                                                         fill_load,
  input  logic [cache_geom_pkg::word_w-1:0]                            cpu_req_addr,
  input  logic                                                         cpu_req_rw,
  input  logic [cache_geom_pkg::word_w-1:0]                            cpu_req_datain,
  input  logic [cache_geom_pkg::ways-1:0]                              cand_valid,
  input  logic [cache_geom_pkg::ways-1:0]                              cand_dirty,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   cand_age,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   cand_tag,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] cand_data,
  input  logic [cache_geom_pkg::block_w-1:0]                           mem_req_datain,
  output logic [cache_geom_pkg::tag_w-1:0]                             req_tag,
  output logic [cache_geom_pkg::index_w-1:0]                           req_index,
  output logic [cache_geom_pkg::offset_w-1:0]                          req_offset,
  output logic                                                         req_rw,
  output logic [cache_geom_pkg::word_w-1:0]                            req_data,
  output logic [cache_geom_pkg::ways-1:0]                              line_valid,
  output logic [cache_geom_pkg::ways-1:0]                              line_dirty,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   line_age,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   line_tag,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] line_data,
  output logic [cache_geom_pkg::block_w-1:0]                           fill_block
);

  cache_geom_pkg::cache_addr_u addr_q;  // Held CPU address

  assign req_tag    = addr_q.fields.tag;
  assign req_index  = addr_q.fields.index;
  assign req_offset = addr_q.fields.offset;

  always_ff @(posedge clk) begin
    if (req_load) begin  // Only taken in idle
      addr_q.raw <= cpu_req_addr;
      req_rw     <= cpu_req_rw;
      req_data   <= cpu_req_datain;
    end
    // Array read result, one set of four ways
    if (cand_load) begin
      line_valid <= cand_valid;
      line_dirty <= cand_dirty;
      line_age   <= cand_age;
      line_tag   <= cand_tag;
      line_data  <= cand_data;
    end
    if (fill_load) begin
      // Write miss merges the CPU word into the fetched block
      fill_block <= req_rw ? cache_geom_pkg::merge_word(mem_req_datain, req_offset, req_data)
                           : mem_req_datain;
    end
  end

  // Request and array answer belong to different phases of one access
  req_vs_cand_a: assert property (@(posedge clk) disable iff (!rst_n)
                                  !(req_load && cand_load))
    else $error("line_buffer: request and candidate load in the same cycle");

endmodule

`default_nettype wire

/* design/miss_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module miss_fsm (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 cpu_req_enable,
  input  logic                                 cache_ready,
  input  logic                                 mem_req_ready,
  input  logic                                 hit,
  input  logic                                 evict_needed,
  input  logic [cache_geom_pkg::tag_w-1:0]     victim_tag,
  input  logic [cache_geom_pkg::tag_w-1:0]     req_tag,
  input  logic [cache_geom_pkg::index_w-1:0]   req_index,
  input  logic                                 req_rw,
  output logic                                 req_load,
  output logic                                 cand_load,
  output logic                                 fill_load,
  output logic                                 cache_enable,
  output logic                                 cache_rw,
  output logic [cache_geom_pkg::index_w-1:0]   cache_index,
  output logic                                 mem_req_enable,
  output logic                                 mem_req_rw,
  output logic [cache_geom_pkg::word_w-1:0]    mem_req_addr,
  output logic                                 cpu_res_ready
);

  cache_ctrl_pkg::ctrl_state_e state, state_next;
  logic                        fill_done;  // Block fetched for this access
  logic                        commit;     // Line ready to be written to the array
  cache_geom_pkg::cache_addr_u blk_addr;

  // Candidates land at the end of lookup, so hit is first known in update
  assign commit = hit || fill_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= cache_ctrl_pkg::idle;
      fill_done <= 1'b0;
    end else begin
      state <= state_next;
      if (req_load)
        fill_done <= 1'b0;
      else if (fill_load)
        fill_done <= 1'b1;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      cache_ctrl_pkg::idle:     if (cpu_req_enable) state_next = cache_ctrl_pkg::lookup;
      cache_ctrl_pkg::lookup:   if (cache_ready) state_next = cache_ctrl_pkg::update;
      cache_ctrl_pkg::update: begin
        if (!commit)  // Miss found, go fetch the block first
          state_next = evict_needed ? cache_ctrl_pkg::evict : cache_ctrl_pkg::allocate;
        else if (cache_ready)
          state_next = cache_ctrl_pkg::respond;
      end
      cache_ctrl_pkg::evict:    if (mem_req_ready) state_next = cache_ctrl_pkg::allocate;
      cache_ctrl_pkg::allocate: if (mem_req_ready) state_next = cache_ctrl_pkg::update;
      default:                  state_next = cache_ctrl_pkg::idle;  // respond lasts one cycle
    endcase
  end

  // Line buffer strobes
  assign req_load  = (state == cache_ctrl_pkg::idle) && cpu_req_enable;
  assign cand_load = (state == cache_ctrl_pkg::lookup) && cache_ready;
  assign fill_load = (state == cache_ctrl_pkg::allocate) && mem_req_ready;

  // Array port, held until cache_ready
  assign cache_enable = (state == cache_ctrl_pkg::lookup) ||
                        ((state == cache_ctrl_pkg::update) && commit);
  assign cache_rw     = (state == cache_ctrl_pkg::update);
  assign cache_index  = req_index;

  // Memory port, held until mem_req_ready
  assign mem_req_enable = (state == cache_ctrl_pkg::evict) || (state == cache_ctrl_pkg::allocate);
  assign mem_req_rw     = (state == cache_ctrl_pkg::evict);

  always_comb begin
    blk_addr              = '0;  // Block aligned, offset stays zero
    blk_addr.fields.tag   = (state == cache_ctrl_pkg::evict) ? victim_tag : req_tag;
    blk_addr.fields.index = req_index;
  end
  assign mem_req_addr = blk_addr.raw;

  assign cpu_res_ready = (state == cache_ctrl_pkg::respond);

  // One bus at a time
  bus_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
                               !(cache_enable && mem_req_enable))
    else $error("miss_fsm: array and memory enabled together");

  // Held request must not move under an access in flight
  req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
                                 (state != cache_ctrl_pkg::idle) |=>
                                 $stable({req_tag, req_index, req_rw}))
    else $error("miss_fsm: request changed during an access");

endmodule

`default_nettype wire

/* design/way_lookup.sv */
`timescale 1ns/100ps
`default_nettype none

module way_lookup (
  input  logic [cache_geom_pkg::tag_w-1:0]                             req_tag,
  input  logic [cache_geom_pkg::offset_w-1:0]                          req_offset,
  input  logic                                                         req_rw,
  input  logic [cache_geom_pkg::word_w-1:0]                            req_data,
  input  logic [cache_geom_pkg::ways-1:0]                              line_valid,
  input  logic [cache_geom_pkg::ways-1:0]                              line_dirty,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   line_age,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   line_tag,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] line_data,
  input  logic [cache_geom_pkg::block_w-1:0]                           fill_block,
  output logic                                                         hit,
  output logic                                                         evict_needed,
  output logic [cache_geom_pkg::tag_w-1:0]                             victim_tag,
  output logic [cache_geom_pkg::block_w-1:0]                           victim_block,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   way_age,
  output logic [cache_geom_pkg::tag_w-1:0]                             wr_tag,
  output logic                                                         wr_dirty,
  output logic [cache_geom_pkg::block_w-1:0]                           wr_data,
  output logic [cache_geom_pkg::ways-1:0]                              bank_selector,
  output logic [cache_geom_pkg::word_w-1:0]                            read_word
);

  logic [cache_geom_pkg::ways-1:0]    hit_way;     // Valid way with matching tag
  logic [cache_geom_pkg::ways-1:0]    oldest_way;  // LRU candidate
  logic [cache_geom_pkg::age_w-1:0]   sel_age;     // Old age of the accessed way
  logic                               sel_valid;
  logic                               sel_dirty;
  logic [cache_geom_pkg::tag_w-1:0]   sel_tag;
  logic [cache_geom_pkg::block_w-1:0] sel_block;

  always_comb begin
    for (int w = 0; w < cache_geom_pkg::ways; w++) begin
      hit_way[w]    = line_valid[w] && (line_tag[w] == req_tag);
      oldest_way[w] = (line_age[w] == cache_ctrl_pkg::age_oldest);
    end
  end

  assign hit           = |hit_way;
  assign bank_selector = hit ? hit_way : oldest_way;  // Hit way, else the victim

  // Fields of the accessed way
  always_comb begin
    sel_age   = '0;
    sel_valid = 1'b0;
    sel_dirty = 1'b0;
    sel_tag   = '0;
    sel_block = '0;
    for (int w = 0; w < cache_geom_pkg::ways; w++) begin
      if (bank_selector[w]) begin
        sel_age   = line_age[w];
        sel_valid = line_valid[w];
        sel_dirty = line_dirty[w];
        sel_tag   = line_tag[w];
        sel_block = line_data[w];
      end
    end
  end

  assign evict_needed = !hit && sel_valid && sel_dirty;
  assign victim_tag   = sel_tag;    // Victim's own tag for the write-back address
  assign victim_block = sel_block;

  // Accessed way becomes newest, younger ways age by one, so ages stay a permutation
  always_comb begin
    for (int w = 0; w < cache_geom_pkg::ways; w++) begin
      if (bank_selector[w])
        way_age[w] = cache_ctrl_pkg::age_newest;
      else if (line_age[w] < sel_age)
        way_age[w] = cache_geom_pkg::age_w'(line_age[w] + 1'b1);
      else
        way_age[w] = line_age[w];
    end
  end

  always_comb begin
    wr_tag = req_tag;
    if (hit) begin
      wr_data  = req_rw ? cache_geom_pkg::merge_word(sel_block, req_offset, req_data)
                        : sel_block;
      wr_dirty = sel_dirty || req_rw;  // Read hit keeps its dirty bit
    end else begin
      wr_data  = fill_block;           // Already merged on a write miss
      wr_dirty = req_rw;
    end
  end

  assign read_word = wr_data[req_offset*cache_geom_pkg::word_w +: cache_geom_pkg::word_w];

  // Ages are all zero only before the first array read
  always_comb begin
    if (line_age != '0)
      assert ($onehot(bank_selector))
        else $error("way_lookup: bank_selector not one-hot, tags or ages corrupt");
  end

endmodule

`default_nettype wire

/* tb/cache_env_model.sv */
`timescale 1ns/100ps
`default_nettype none

module cache_env_model (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  input  logic                                                         cache_enable,
  input  logic                                                         cache_rw,
  input  logic [cache_geom_pkg::index_w-1:0]                           cache_index,
  output logic                                                         cache_ready,
  output logic [cache_geom_pkg::ways-1:0]                              cand_valid,
  output logic [cache_geom_pkg::ways-1:0]                              cand_dirty,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   cand_age,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   cand_tag,
  output logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] cand_data,
  input  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   way_age,
  input  logic [cache_geom_pkg::tag_w-1:0]                             wr_tag,
  input  logic                                                         wr_dirty,
  input  logic [cache_geom_pkg::block_w-1:0]                           wr_data,
  input  logic [cache_geom_pkg::ways-1:0]                              bank_selector,
  input  logic [cache_geom_pkg::word_w-1:0]                            mem_req_addr,
  input  logic [cache_geom_pkg::block_w-1:0]                           mem_req_dataout,
  input  logic                                                         mem_req_rw,
  input  logic                                                         mem_req_enable,
  output logic [cache_geom_pkg::block_w-1:0]                           mem_req_datain,
  output logic                                                         mem_req_ready
);

  localparam int sets       = 2 ** cache_geom_pkg::index_w;
  localparam int blk_addr_w = cache_geom_pkg::word_w - cache_geom_pkg::offset_w;

  logic [cache_geom_pkg::ways-1:0]                              valid_q [sets];
  logic [cache_geom_pkg::ways-1:0]                              dirty_q [sets];
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   age_q   [sets];
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   tag_q   [sets];
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] data_q  [sets];
  logic [cache_geom_pkg::block_w-1:0] mem_q [logic [blk_addr_w-1:0]];  // Written-back blocks

  // Untouched memory holds word address XOR 5A5A0000
  function automatic logic [cache_geom_pkg::block_w-1:0] block_at(
      input logic [blk_addr_w-1:0] blk);
    logic [cache_geom_pkg::block_w-1:0] block;
    if (mem_q.exists(blk))
      return mem_q[blk];
    for (int i = 0; i < cache_geom_pkg::block_words; i++)
      block[i*cache_geom_pkg::word_w +: cache_geom_pkg::word_w] =
        {blk, i[cache_geom_pkg::offset_w-1:0]} ^ 32'h5A5A0000;
    return block;
  endfunction

  // Array answers one cycle after the enable, ready is a single pulse
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cache_ready <= 1'b0;
      cand_valid  <= '0;
      cand_dirty  <= '0;
      cand_age    <= '0;
      cand_tag    <= '0;
      cand_data   <= '0;
      for (int s = 0; s < sets; s++) begin
        valid_q[s] <= '0;  // All lines invalid
        dirty_q[s] <= '0;
        tag_q[s]   <= '0;
        for (int w = 0; w < cache_geom_pkg::ways; w++)
          age_q[s][w] <= cache_geom_pkg::age_w'(w);  // Ages 0..3 by way
      end
    end else if (cache_enable && !cache_ready) begin
      cache_ready <= 1'b1;
      if (cache_rw) begin
        age_q[cache_index] <= way_age;  // Ages of the whole set
        for (int w = 0; w < cache_geom_pkg::ways; w++) begin
          if (bank_selector[w]) begin
            valid_q[cache_index][w] <= 1'b1;
            dirty_q[cache_index][w] <= wr_dirty;
            tag_q[cache_index][w]   <= wr_tag;
            data_q[cache_index][w]  <= wr_data;
          end
        end
      end else begin
        cand_valid <= valid_q[cache_index];
        cand_dirty <= dirty_q[cache_index];
        cand_age   <= age_q[cache_index];
        cand_tag   <= tag_q[cache_index];
        cand_data  <= data_q[cache_index];
      end
    end else begin
      cache_ready <= 1'b0;
    end
  end

  // Block-wide main memory with the same one-cycle answer
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_req_ready  <= 1'b0;
      mem_req_datain <= '0;
    end else if (mem_req_enable && !mem_req_ready) begin
      mem_req_ready <= 1'b1;
      if (mem_req_rw)
        mem_q[mem_req_addr[cache_geom_pkg::word_w-1:cache_geom_pkg::offset_w]] = mem_req_dataout;
      else
        mem_req_datain <= block_at(mem_req_addr[cache_geom_pkg::word_w-1:cache_geom_pkg::offset_w]);
    end else begin
      mem_req_ready <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* tb/cache_vectors.txt */
# name  op(rd|wr)  address  write_data  expected_word   (all values hex)
# expected_word is the word returned on cpu_res_dataout
rd_miss_clean        rd 00000010 00000000 5a5a0010
rd_hit_same_block    rd 00000013 00000000 5a5a0013
wr_hit               wr 00000015 cafe0015 cafe0015
rd_after_wr_hit      rd 00000015 00000000 cafe0015
wr_miss_merge        wr 00000025 beef0025 beef0025
rd_merged_word       rd 00000025 00000000 beef0025
rd_merged_neighbor   rd 00000026 00000000 5a5a0026
lru_tag1_dirty       wr 00000853 11112222 11112222
lru_tag2             rd 00001050 00000000 5a5a1050
lru_tag3             rd 00001857 00000000 5a5a1857
lru_tag4             rd 0000205a 00000000 5a5a205a
lru_tag5_evicts      rd 0000285f 00000000 5a5a285f
lru_refill_written   rd 00000853 00000000 11112222
lru_refill_neighbor  rd 00000852 00000000 5a5a0852

/* tb/tb_cache_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_cache_controller;

  localparam int    timeout_cycles = 200;                    // Per access wait limit
  localparam string vector_path    = "tb/cache_vectors.txt";

  logic                                                         clk;
  logic                                                         rst_n;
  logic [cache_geom_pkg::word_w-1:0]                            cpu_req_addr;
  logic [cache_geom_pkg::word_w-1:0]                            cpu_req_datain;
  logic                                                         cpu_req_rw;
  logic                                                         cpu_req_enable;
  logic [cache_geom_pkg::word_w-1:0]                            cpu_res_dataout;
  logic                                                         cpu_res_ready;
  logic                                                         cache_enable;
  logic                                                         cache_rw;
  logic [cache_geom_pkg::index_w-1:0]                           cache_index;
  logic                                                         cache_ready;
  logic [cache_geom_pkg::ways-1:0]                              cand_valid;
  logic [cache_geom_pkg::ways-1:0]                              cand_dirty;
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   cand_age;
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::tag_w-1:0]   cand_tag;
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::block_w-1:0] cand_data;
  logic [cache_geom_pkg::ways-1:0][cache_geom_pkg::age_w-1:0]   way_age;
  logic [cache_geom_pkg::tag_w-1:0]                             wr_tag;
  logic                                                         wr_dirty;
  logic [cache_geom_pkg::block_w-1:0]                           wr_data;
  logic [cache_geom_pkg::ways-1:0]                              bank_selector;
  logic [cache_geom_pkg::word_w-1:0]                            mem_req_addr;
  logic [cache_geom_pkg::block_w-1:0]                           mem_req_dataout;
  logic                                                         mem_req_rw;
  logic                                                         mem_req_enable;
  logic [cache_geom_pkg::block_w-1:0]                           mem_req_datain;
  logic                                                         mem_req_ready;

  cache_controller cache_controller_inst (.*);

  cache_env_model env_model_inst (.*);  // Array and memory responders

  initial clk = 1'b0;
  always #20 clk = ~clk;  // 40 ns period

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Polls on the falling edge, where the respond pulse is settled
  task automatic wait_response(input string name);
    int cycles;
    cycles = 0;
    while (cpu_res_ready !== 1'b1) begin
      if (cycles >= timeout_cycles) begin
        stop_on_error($sformatf("%s: no cpu_res_ready within %0d cycles", name, timeout_cycles));
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
  endtask

  task automatic run_access(input string name, input string op,
                            input logic [cache_geom_pkg::word_w-1:0] addr,
                            input logic [cache_geom_pkg::word_w-1:0] wdata,
                            input logic [cache_geom_pkg::word_w-1:0] expected);
    @(negedge clk);
    cpu_req_enable = 1'b1;        // One-cycle request
    cpu_req_rw     = (op == "wr");
    cpu_req_addr   = addr;
    cpu_req_datain = wdata;
    @(negedge clk);
    cpu_req_enable = 1'b0;
    wait_response(name);
    assert (cpu_res_dataout === expected)
      else stop_on_error($sformatf("MISMATCH %s expected %h actual %h",
                                   name, expected, cpu_res_dataout));
    @(negedge clk);
    // Answer is a single pulse
    assert (cpu_res_ready === 1'b0)
      else stop_on_error($sformatf("%s: cpu_res_ready stayed high past one cycle", name));
  endtask

  initial begin
    int                                fd;
    int                                got;
    int                                count;
    int                                n_run;
    string                             line;
    string                             name;
    string                             op;
    logic [cache_geom_pkg::word_w-1:0] addr;
    logic [cache_geom_pkg::word_w-1:0] wdata;
    logic [cache_geom_pkg::word_w-1:0] expected;
    n_run          = 0;
    rst_n          = 1'b0;
    cpu_req_enable = 1'b0;
    cpu_req_rw     = 1'b0;
    cpu_req_addr   = '0;
    cpu_req_datain = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // Quiet outputs before the first request
    repeat (5) begin
      @(negedge clk);
      assert ({cpu_res_ready, cache_enable, mem_req_enable} === 3'b000)
        else stop_on_error($sformatf("MISMATCH reset_idle expected 000 actual %b",
                                     {cpu_res_ready, cache_enable, mem_req_enable}));
    end
    fd = $fopen(vector_path, "r");
    if (fd == 0) begin
      stop_on_error("could not open the vectors file");
    end else begin
      while (!$feof(fd)) begin
        got = $fgets(line, fd);
        if (got > 0 && line.getc(0) != "#") begin  // Skip column notes
          count = $sscanf(line, "%s %s %h %h %h", name, op, addr, wdata, expected);
          if (count == 5) begin
            run_access(name, op, addr, wdata, expected);
            n_run++;
          end
        end
      end
      $fclose(fd);
      if (n_run == 0) begin
        stop_on_error("the vectors file held no usable lines");
      end else begin
        $display("%0d vectors checked", n_run);
        $display("All tests passed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire
